/* lsqConfigPkg.sv */
`default_nettype none

// default sizing for the load/store queue control
// the top level picks these up as parameter defaults and passes them down
package lsqConfigPkg;

  // memory ops accepted per dispatch group
  parameter int DefaultDispatchWidth = 4;

  // retire slots per cycle, shared by loads and stores
  parameter int DefaultCommitWidth = 4;

  // entries per queue, same for load and store side
  // not required to be a power of two
  // pointers wrap explicitly
  parameter int DefaultQueueDepth = 12;

endpackage

`default_nettype wire

/* lsqOpsPkg.sv */
`default_nettype none

// per-lane memory operation encoding seen at dispatch
package lsqOpsPkg;

  // width of the lane kind field
  parameter int OpKindBits = 2;

  // what a dispatch lane carries
  // opNone covers both empty lanes and non-memory ops
  typedef enum logic [OpKindBits-1:0] {
    opNone  = 2'd0,
    opLoad  = 2'd1,
    opStore = 2'd2
  } lsqOpKind_t;

endpackage

`default_nettype wire

/* lsqDispatchDecode.sv */
`default_nettype none

module lsqDispatchDecode
  import lsqConfigPkg::*;
  import lsqOpsPkg::*;
#(
  parameter int dispatchWidth = DefaultDispatchWidth,
  parameter int queueDepth = DefaultQueueDepth,
  localparam int idxBits = $clog2(queueDepth),
  localparam int laneCntBits = $clog2(dispatchWidth + 1)
)
(
  input wire logic dispatchReady_i,
  input wire lsqOpKind_t opKind_i [dispatchWidth],
  input wire logic [idxBits-1:0] loadTail_i,
  input wire logic [idxBits-1:0] storeTail_i,
  output logic [idxBits-1:0] loadId_o [dispatchWidth],
  output logic [idxBits-1:0] storeId_o [dispatchWidth],
  output logic [idxBits-1:0] lsqId_o [dispatchWidth],
  output logic [laneCntBits-1:0] newLoadCount_o,
  output logic [laneCntBits-1:0] newStoreCount_o
);

  // tail plus offset, folded back once at queueDepth
  // offset never exceeds the group width, so one subtract is enough
  function automatic logic [idxBits-1:0] wrapAdd(input logic [idxBits-1:0] base,
                                                 input logic [laneCntBits-1:0] step);
    logic [idxBits:0] sum;
    sum = {1'b0, base} + (idxBits + 1)'(step);
    if (sum >= queueDepth)
    begin
      sum = sum - (idxBits + 1)'(queueDepth);
    end
    return sum[idxBits-1:0];
  endfunction

  // running per-kind counts across the lanes
  logic [laneCntBits-1:0] loadsBefore;
  logic [laneCntBits-1:0] storesBefore;

  always_comb
  begin
    loadsBefore = '0;
    storesBefore = '0;
    for (int lane = 0; lane < dispatchWidth; lane++)
    begin
      // candidate slots, taken from earlier same-kind lanes only
      loadId_o[lane] = wrapAdd(loadTail_i, loadsBefore);
      storeId_o[lane] = wrapAdd(storeTail_i, storesBefore);
      lsqId_o[lane] = '0;
      case (opKind_i[lane])
        opLoad:
        begin
          loadsBefore = loadsBefore + 1'b1;
          // merged id follows the op down the pipe
          if (dispatchReady_i)
          begin
            lsqId_o[lane] = loadId_o[lane];
          end
        end
        opStore:
        begin
          storesBefore = storesBefore + 1'b1;
          if (dispatchReady_i)
          begin
            lsqId_o[lane] = storeId_o[lane];
          end
        end
        default:
        begin
          // opNone, nothing allocated
        end
      endcase
    end
  end

  // group totals only move the tails when the group is really dispatched
  assign newLoadCount_o = dispatchReady_i ? loadsBefore : '0;
  assign newStoreCount_o = dispatchReady_i ? storesBefore : '0;

endmodule

`default_nettype wire

/* loadQueueCtrl.sv */
`default_nettype none

module loadQueueCtrl
  import lsqConfigPkg::*;
  import lsqOpsPkg::*;
#(
  parameter int dispatchWidth = DefaultDispatchWidth,
  parameter int commitWidth = DefaultCommitWidth,
  parameter int queueDepth = DefaultQueueDepth,
  localparam int idxBits = $clog2(queueDepth),
  localparam int cntBits = $clog2(queueDepth + 1),
  localparam int laneCntBits = $clog2(dispatchWidth + 1)
)
(
  input wire logic clk,
  input wire logic reset,
  input wire logic recoverFlag_i,
  input wire logic dispatchReady_i,
  input wire lsqOpKind_t opKind_i [dispatchWidth],
  input wire logic [idxBits-1:0] loadId_i [dispatchWidth],
  input wire logic [laneCntBits-1:0] newLoadCount_i,
  input wire logic [commitWidth-1:0] commitLoad_i,
  output logic [idxBits-1:0] loadHead_o,
  output logic [idxBits-1:0] loadTail_o,
  output logic [cntBits-1:0] loadCount_o
);

  localparam int commitCntBits = $clog2(commitWidth + 1);

  logic [idxBits-1:0] loadHead;
  logic [idxBits-1:0] loadTail;
  logic [cntBits-1:0] loadCount;
  logic [queueDepth-1:0] loadValid;
  logic [commitCntBits-1:0] commitCount;
  logic [queueDepth-1:0] retireMask;
  logic [queueDepth-1:0] allocMask;

  function automatic logic [idxBits-1:0] wrapAdd(input logic [idxBits-1:0] base,
                                                 input int unsigned step);
    logic [idxBits:0] sum;
    sum = {1'b0, base} + (idxBits + 1)'(step);
    if (sum >= queueDepth)
    begin
      sum = sum - (idxBits + 1)'(queueDepth);
    end
    return sum[idxBits-1:0];
  endfunction

  // loads retiring this cycle, any slot pattern
  always_comb
  begin
    commitCount = '0;
    for (int i = 0; i < commitWidth; i++)
    begin
      commitCount = commitCount + commitCntBits'(commitLoad_i[i]);
    end
  end

  // entries leaving from the head, in order
  always_comb
  begin
    retireMask = '0;
    for (int i = 0; i < commitWidth; i++)
    begin
      if (i < commitCount)
      begin
        retireMask[wrapAdd(loadHead, i)] = 1'b1;
      end
    end
  end

  // entries filled by the current dispatch group
  always_comb
  begin
    allocMask = '0;
    for (int lane = 0; lane < dispatchWidth; lane++)
    begin
      if (dispatchReady_i && (opKind_i[lane] == opLoad))
      begin
        allocMask[loadId_i[lane]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      loadHead <= '0;
      loadTail <= '0;
      loadCount <= '0;
      loadValid <= '0;
    end
    else if (recoverFlag_i)
    begin
      // every load is younger than the mispredict point, so all go
      loadHead <= '0;
      loadTail <= '0;
      loadCount <= '0;
      loadValid <= '0;
    end
    else
    begin
      loadHead <= wrapAdd(loadHead, commitCount);
      loadTail <= wrapAdd(loadTail, newLoadCount_i);
      loadCount <= loadCount + cntBits'(newLoadCount_i) - cntBits'(commitCount);
      loadValid <= (loadValid & ~retireMask) | allocMask;
    end
  end

  assign loadHead_o = loadHead;
  assign loadTail_o = loadTail;
  assign loadCount_o = loadCount;

  // occupancy in range, commit never retires more loads than are held
  loadCountBounds: assert property (@(posedge clk) disable iff (reset)
    (loadCount <= queueDepth) && (commitCount <= loadCount))
    else $error("load queue count out of range or commit overrun");

  // only dispatched loads may retire
  loadRetireValid: assert property (@(posedge clk) disable iff (reset)
    !recoverFlag_i |-> ((retireMask & ~loadValid) == '0))
    else $error("load retired from an empty slot");

endmodule

`default_nettype wire

/* storeQueueCtrl.sv */
`default_nettype none

module storeQueueCtrl
  import lsqConfigPkg::*;
  import lsqOpsPkg::*;
#(
  parameter int dispatchWidth = DefaultDispatchWidth,
  parameter int commitWidth = DefaultCommitWidth,
  parameter int queueDepth = DefaultQueueDepth,
  localparam int idxBits = $clog2(queueDepth),
  localparam int cntBits = $clog2(queueDepth + 1),
  localparam int laneCntBits = $clog2(dispatchWidth + 1)
)
(
  input wire logic clk,
  input wire logic reset,
  input wire logic recoverFlag_i,
  input wire logic dispatchReady_i,
  input wire lsqOpKind_t opKind_i [dispatchWidth],
  input wire logic [idxBits-1:0] storeId_i [dispatchWidth],
  input wire logic [laneCntBits-1:0] newStoreCount_i,
  input wire logic [commitWidth-1:0] commitStore_i,
  input wire logic stallStore_i,
  output logic [idxBits-1:0] storeHead_o,
  output logic [idxBits-1:0] storeTail_o,
  output logic [cntBits-1:0] storeCount_o,
  output logic storeDrain_o
);

  localparam int commitCntBits = $clog2(commitWidth + 1);

  logic [idxBits-1:0] storeHead;
  logic [idxBits-1:0] storeTail;
  // first store not yet retired
  logic [idxBits-1:0] commitPtr;
  logic [cntBits-1:0] storeCount;
  logic [queueDepth-1:0] storeValid;
  // retired but still waiting for the cache
  logic [queueDepth-1:0] storeCommitted;
  logic [commitCntBits-1:0] commitCount;
  logic [queueDepth-1:0] commitMask;
  logic [queueDepth-1:0] allocMask;
  logic [queueDepth-1:0] drainMask;
  logic [queueDepth-1:0] keptValid;
  logic [cntBits-1:0] keptCount;

  function automatic logic [idxBits-1:0] wrapAdd(input logic [idxBits-1:0] base,
                                                 input int unsigned step);
    logic [idxBits:0] sum;
    sum = {1'b0, base} + (idxBits + 1)'(step);
    if (sum >= queueDepth)
    begin
      sum = sum - (idxBits + 1)'(queueDepth);
    end
    return sum[idxBits-1:0];
  endfunction

  // head store goes to the cache when retired and the cache can take it
  assign storeDrain_o = storeValid[storeHead] & storeCommitted[storeHead] & ~stallStore_i;

  always_comb
  begin
    drainMask = '0;
    drainMask[storeHead] = storeDrain_o;
  end

  // retiring stores mark consecutive entries from the commit pointer
  always_comb
  begin
    commitCount = '0;
    commitMask = '0;
    for (int i = 0; i < commitWidth; i++)
    begin
      commitCount = commitCount + commitCntBits'(commitStore_i[i]);
    end
    for (int i = 0; i < commitWidth; i++)
    begin
      if (i < commitCount)
      begin
        commitMask[wrapAdd(commitPtr, i)] = 1'b1;
      end
    end
  end

  always_comb
  begin
    allocMask = '0;
    for (int lane = 0; lane < dispatchWidth; lane++)
    begin
      if (dispatchReady_i && (opKind_i[lane] == opStore))
      begin
        allocMask[storeId_i[lane]] = 1'b1;
      end
    end
  end

  // on recovery only retired stores survive, they are older than the branch
  always_comb
  begin
    keptValid = storeValid & storeCommitted;
    keptCount = '0;
    for (int i = 0; i < queueDepth; i++)
    begin
      keptCount = keptCount + cntBits'(keptValid[i]);
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      storeHead <= '0;
      storeTail <= '0;
      commitPtr <= '0;
      storeCount <= '0;
      storeValid <= '0;
      storeCommitted <= '0;
    end
    else if (recoverFlag_i)
    begin
      // head and commit pointer hold, tail snaps back
      storeTail <= commitPtr;
      storeCount <= keptCount;
      storeValid <= keptValid;
    end
    else
    begin
      storeHead <= wrapAdd(storeHead, storeDrain_o);
      storeTail <= wrapAdd(storeTail, newStoreCount_i);
      commitPtr <= wrapAdd(commitPtr, commitCount);
      storeCount <= storeCount + cntBits'(newStoreCount_i) - cntBits'(storeDrain_o);
      storeValid <= (storeValid & ~drainMask) | allocMask;
      storeCommitted <= (storeCommitted & ~drainMask) | commitMask;
    end
  end

  assign storeHead_o = storeHead;
  assign storeTail_o = storeTail;
  assign storeCount_o = storeCount;

  // a stalled cache sees no store and the head stays put
  storeStallHolds: assert property (@(posedge clk) disable iff (reset)
    stallStore_i |-> !storeDrain_o ##1 $stable(storeHead))
    else $error("store drained or head moved under cache stall");

  // recovery leaves no room between tail and the retired stores
  storeRecoverTail: assert property (@(posedge clk) disable iff (reset)
    recoverFlag_i |=> (storeTail == commitPtr))
    else $error("store tail not at commit pointer after recovery");

endmodule

`default_nettype wire

/* lsqControl.sv */
`default_nettype none

module lsqControl
  import lsqConfigPkg::*;
  import lsqOpsPkg::*;
#(
  parameter int dispatchWidth = DefaultDispatchWidth,
  parameter int commitWidth = DefaultCommitWidth,
  parameter int queueDepth = DefaultQueueDepth,
  localparam int idxBits = $clog2(queueDepth),
  localparam int cntBits = $clog2(queueDepth + 1),
  localparam int laneCntBits = $clog2(dispatchWidth + 1)
)
(
  input wire logic clk,
  input wire logic reset,
  input wire logic recoverFlag_i,
  input wire logic dispatchReady_i,
  input wire lsqOpKind_t opKind_i [dispatchWidth],
  input wire logic [commitWidth-1:0] commitLoad_i,
  input wire logic [commitWidth-1:0] commitStore_i,
  input wire logic stallStore_i,
  output wire logic [idxBits-1:0] lsqId_o [dispatchWidth],
  output wire logic [idxBits-1:0] loadId_o [dispatchWidth],
  output wire logic [idxBits-1:0] storeId_o [dispatchWidth],
  output wire logic [idxBits-1:0] loadHead_o,
  output wire logic [idxBits-1:0] loadTail_o,
  output wire logic [cntBits-1:0] loadCount_o,
  output wire logic [idxBits-1:0] storeHead_o,
  output wire logic [idxBits-1:0] storeTail_o,
  output wire logic [cntBits-1:0] storeCount_o,
  output wire logic storeDrain_o
);

  // per-kind group sizes from decode to the queues
  wire logic [laneCntBits-1:0] newLoadCount;
  wire logic [laneCntBits-1:0] newStoreCount;

  // tails feed back into decode for the next group
  lsqDispatchDecode #(
    .dispatchWidth(dispatchWidth),
    .queueDepth(queueDepth)
  ) decode (
    .dispatchReady_i(dispatchReady_i),
    .opKind_i(opKind_i),
    .loadTail_i(loadTail_o),
    .storeTail_i(storeTail_o),
    .loadId_o(loadId_o),
    .storeId_o(storeId_o),
    .lsqId_o(lsqId_o),
    .newLoadCount_o(newLoadCount),
    .newStoreCount_o(newStoreCount)
  );

  loadQueueCtrl #(
    .dispatchWidth(dispatchWidth),
    .commitWidth(commitWidth),
    .queueDepth(queueDepth)
  ) loadQueue (
    .clk(clk),
    .reset(reset),
    .recoverFlag_i(recoverFlag_i),
    .dispatchReady_i(dispatchReady_i),
    .opKind_i(opKind_i),
    .loadId_i(loadId_o),
    .newLoadCount_i(newLoadCount),
    .commitLoad_i(commitLoad_i),
    .loadHead_o(loadHead_o),
    .loadTail_o(loadTail_o),
    .loadCount_o(loadCount_o)
  );

  storeQueueCtrl #(
    .dispatchWidth(dispatchWidth),
    .commitWidth(commitWidth),
    .queueDepth(queueDepth)
  ) storeQueue (
    .clk(clk),
    .reset(reset),
    .recoverFlag_i(recoverFlag_i),
    .dispatchReady_i(dispatchReady_i),
    .opKind_i(opKind_i),
    .storeId_i(storeId_o),
    .newStoreCount_i(newStoreCount),
    .commitStore_i(commitStore_i),
    .stallStore_i(stallStore_i),
    .storeHead_o(storeHead_o),
    .storeTail_o(storeTail_o),
    .storeCount_o(storeCount_o),
    .storeDrain_o(storeDrain_o)
  );

endmodule

`default_nettype wire

/* lsqControlTbTasks.svh */
`ifndef LSQ_CONTROL_TB_TASKS_SVH
`define LSQ_CONTROL_TB_TASKS_SVH

// compare one DUT value against the model
task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
  if (actual !== expected)
  begin
    errorCount++;
    $display("ERROR at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
    $display("Simulation FAILED");
    $fatal(1, "mismatch on %s", what);
  end
endtask

// all registered state against the model
task automatic checkCounts();
  checkValue(loadCount, expLoadCount, "load count");
  checkValue(loadHead, expLoadHead, "load head");
  checkValue(loadTail, expLoadTail, "load tail");
  checkValue(storeCount, expUncommitted + expCommitted, "store count");
  checkValue(storeHead, expStoreHead, "store head");
  checkValue(storeTail, expStoreTail, "store tail");
endtask

// one dispatch group with two mix bits per lane
// lane 0 sits in the low bits
task automatic driveDispatch(input logic [2*laneCount-1:0] mix);
  int loads;
  int stores;
  int slot;
  loads = 0;
  stores = 0;
  for (int l = 0; l < laneCount; l++)
  begin
    opKind[l] = lsqOpKind_t'(mix[2*l +: 2]);
  end
  dispatchReady = 1'b1;
  #1;
  for (int l = 0; l < laneCount; l++)
  begin
    if (opKind[l] == opLoad)
    begin
      // tail plus loads in earlier lanes
      slot = (expLoadTail + loads) % queueDepth;
      checkValue(loadId[l], slot, "load index");
      checkValue(lsqId[l], slot, "merged index on load lane");
      loads++;
    end
    else if (opKind[l] == opStore)
    begin
      slot = (expStoreTail + stores) % queueDepth;
      checkValue(storeId[l], slot, "store index");
      checkValue(lsqId[l], slot, "merged index on store lane");
      stores++;
    end
    else
    begin
      checkValue(lsqId[l], 0, "merged index on empty lane");
    end
  end
  expLoadTail = (expLoadTail + loads) % queueDepth;
  expLoadCount += loads;
  expStoreTail = (expStoreTail + stores) % queueDepth;
  expUncommitted += stores;
  @(posedge clk);
  #1;
  dispatchReady = 1'b0;
  for (int l = 0; l < laneCount; l++)
  begin
    opKind[l] = opNone;
  end
  checkCounts();
endtask

// loads retire from the upper slots and stores from the lower ones
task automatic driveCommit(input int loads, input int stores);
  commitLoad = slotCount'(((1 << loads) - 1) << (slotCount - loads));
  commitStore = slotCount'((1 << stores) - 1);
  @(posedge clk);
  #1;
  commitLoad = '0;
  commitStore = '0;
  expLoadHead = (expLoadHead + loads) % queueDepth;
  expLoadCount -= loads;
  expCommitPtr = (expCommitPtr + stores) % queueDepth;
  expUncommitted -= stores;
  expCommitted += stores;
  checkCounts();
endtask

// poll the drain strobe until the head store leaves
task automatic waitForDrain();
  int waited;
  bit seen;
  waited = 0;
  seen = 1'b0;
  while (!seen && (waited < drainTimeout))
  begin
    #1;
    if (storeDrain)
    begin
      seen = 1'b1;
    end
    else
    begin
      @(posedge clk);
      #1;
      waited++;
    end
  end
  if (!seen)
  begin
    $display("timeout: a committed store was never drained to the cache");
    $display("Simulation FAILED");
    $fatal(1, "drain timeout");
  end
endtask

// open the cache until every committed store is gone
task automatic drainCommitted();
  stallStore = 1'b0;
  while (expCommitted > 0)
  begin
    waitForDrain();
    @(posedge clk);
    #1;
    // exactly one store leaves per edge
    expStoreHead = (expStoreHead + 1) % queueDepth;
    expCommitted--;
    checkCounts();
  end
  // nothing retired is left at the head
  checkValue(storeDrain, 0, "drain strobe with no retired store at the head");
  stallStore = 1'b1;
endtask

task automatic checkResetState();
  checkCounts();
  checkValue(storeDrain, 0, "drain strobe after reset");
  // loads offered while dispatch is idle
  for (int l = 0; l < laneCount; l++)
  begin
    opKind[l] = opLoad;
  end
  #1;
  for (int l = 0; l < laneCount; l++)
  begin
    checkValue(lsqId[l], 0, "merged index while dispatch idle");
  end
  @(posedge clk);
  #1;
  for (int l = 0; l < laneCount; l++)
  begin
    opKind[l] = opNone;
  end
  // nothing allocated by an idle group
  checkCounts();
endtask

task automatic dispatchRandomGroups();
  logic [2*laneCount-1:0] mix;
  // three groups of four fit in an empty queue of twelve
  repeat (3)
  begin
    for (int l = 0; l < laneCount; l++)
    begin
      mix[2*l +: 2] = 2'($unsigned($random(seed)) % 3);
    end
    driveDispatch(mix);
  end
endtask

task automatic retireLoads();
  int k;
  while (expLoadCount > 0)
  begin
    k = (expLoadCount >= 3) ? 3 : expLoadCount;
    driveCommit(k, 0);
  end
  // uneven retire sizes from a full group
  driveDispatch(8'h55);
  driveCommit(1, 0);
  driveCommit(3, 0);
endtask

task automatic drainStores();
  int k;
  if ((expUncommitted + expCommitted) < laneCount)
  begin
    driveDispatch(8'hAA);
  end
  while (expUncommitted > 0)
  begin
    k = (expUncommitted >= slotCount) ? slotCount : expUncommitted;
    driveCommit(0, k);
  end
  // retired stores sit in the queue while the cache stalls
  repeat (3)
  begin
    #1;
    checkValue(storeDrain, 0, "drain strobe under cache stall");
    @(posedge clk);
    #1;
    checkCounts();
  end
  drainCommitted();
endtask

task automatic recoverFromMispredict();
  // five stores and three loads with three stores retired
  driveDispatch(8'h6A);
  driveDispatch(8'h5A);
  driveCommit(1, 3);
  recoverFlag = 1'b1;
  @(posedge clk);
  #1;
  recoverFlag = 1'b0;
  expLoadHead = 0;
  expLoadTail = 0;
  expLoadCount = 0;
  expStoreTail = expCommitPtr;
  expUncommitted = 0;
  checkCounts();
  // new stores start at the rewound tail
  driveDispatch(8'h86);
endtask

task automatic wrapIndices();
  int prevLoad;
  int prevStore;
  bit loadWrapped;
  bit storeWrapped;
  loadWrapped = 1'b0;
  storeWrapped = 1'b0;
  // two of each per round for sixteen slots in total
  repeat (8)
  begin
    prevLoad = loadTail;
    prevStore = storeTail;
    driveDispatch(8'h99);
    // a tail that moved backwards went past the last index
    if (loadTail < prevLoad)
    begin
      loadWrapped = 1'b1;
    end
    if (storeTail < prevStore)
    begin
      storeWrapped = 1'b1;
    end
    driveCommit(2, 2);
    drainCommitted();
  end
  checkValue(loadWrapped, 1, "load tail passed the last index");
  checkValue(storeWrapped, 1, "store tail passed the last index");
endtask

`endif

/* lsqControlTb.sv */
`default_nettype none

module lsqControlTb
  import lsqConfigPkg::*;
  import lsqOpsPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int laneCount = DefaultDispatchWidth;
  localparam int slotCount = DefaultCommitWidth;
  localparam int queueDepth = DefaultQueueDepth;
  localparam int idxBits = $clog2(queueDepth);
  localparam int cntBits = $clog2(queueDepth + 1);
  // cycles a committed store may wait for the cache
  localparam int drainTimeout = 20;

  logic clk;
  logic reset;
  logic recoverFlag;
  logic dispatchReady;
  lsqOpKind_t opKind [laneCount];
  logic [slotCount-1:0] commitLoad;
  logic [slotCount-1:0] commitStore;
  logic stallStore;

  logic [idxBits-1:0] lsqId [laneCount];
  logic [idxBits-1:0] loadId [laneCount];
  logic [idxBits-1:0] storeId [laneCount];
  logic [idxBits-1:0] loadHead;
  logic [idxBits-1:0] loadTail;
  logic [cntBits-1:0] loadCount;
  logic [idxBits-1:0] storeHead;
  logic [idxBits-1:0] storeTail;
  logic [cntBits-1:0] storeCount;
  logic storeDrain;

  // reference model of both queues
  int expLoadHead;
  int expLoadTail;
  int expLoadCount;
  int expStoreHead;
  int expStoreTail;
  int expCommitPtr;
  // stores dispatched but not retired
  int expUncommitted;
  // retired stores still waiting for the cache
  int expCommitted;

  int errorCount;
  int seed;

  lsqControl #(
    .dispatchWidth(laneCount),
    .commitWidth(slotCount),
    .queueDepth(queueDepth)
  ) uut (
    .clk(clk),
    .reset(reset),
    .recoverFlag_i(recoverFlag),
    .dispatchReady_i(dispatchReady),
    .opKind_i(opKind),
    .commitLoad_i(commitLoad),
    .commitStore_i(commitStore),
    .stallStore_i(stallStore),
    .lsqId_o(lsqId),
    .loadId_o(loadId),
    .storeId_o(storeId),
    .loadHead_o(loadHead),
    .loadTail_o(loadTail),
    .loadCount_o(loadCount),
    .storeHead_o(storeHead),
    .storeTail_o(storeTail),
    .storeCount_o(storeCount),
    .storeDrain_o(storeDrain)
  );

  `include "lsqControlTbTasks.svh"

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    seed = 38876;
    errorCount = 0;
    expLoadHead = 0;
    expLoadTail = 0;
    expLoadCount = 0;
    expStoreHead = 0;
    expStoreTail = 0;
    expCommitPtr = 0;
    expUncommitted = 0;
    expCommitted = 0;
    reset = 1'b1;
    recoverFlag = 1'b0;
    dispatchReady = 1'b0;
    for (int l = 0; l < laneCount; l++)
    begin
      opKind[l] = opNone;
    end
    commitLoad = '0;
    commitStore = '0;
    // cache held off unless a test drains on purpose
    stallStore = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;

    checkResetState();
    dispatchRandomGroups();
    retireLoads();
    drainStores();
    recoverFromMispredict();
    wrapIndices();

    if (errorCount == 0)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
    begin
      $display("Simulation FAILED");
      $fatal(1, "%0d checks failed", errorCount);
    end
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
lsqConfigPkg.sv
lsqOpsPkg.sv
lsqDispatchDecode.sv
loadQueueCtrl.sv
storeQueueCtrl.sv
lsqControl.sv
lsqControlTb.sv
